/* design/sampler_pkg.sv */
`default_nettype none

////////////////////
// Sampler shared types
////////////////////

package sampler_pkg;

    // Geometry of the sampler
    localparam int N_CH            = 16;  // Input channels
    localparam int WINDOW          = 64;  // Samples kept per channel
    localparam int SYNC_STAGES_DEF = 2;   // Default synchronizer depth

    // One bit per channel
    // Raw pin levels and detection strobes
    typedef logic [N_CH-1:0] ch_bits_t;

    // History of one channel
    // Bit WINDOW-1 newest, bit 0 oldest
    typedef logic [WINDOW-1:0] window_t;

    // All channel windows side by side, channel c in element c
    typedef window_t [N_CH-1:0] frame_t;

    // Event output of the sampler
    typedef struct packed {
        logic   ready;  // High for the single capture cycle
        frame_t frame;  // Snapshot, zero outside the capture cycle
    } capture_t;

    // Read FSM states
    typedef enum logic [1:0] {
        STAND_BY = 2'd0,  // Idle, watching trig
        READING  = 2'd1,  // Snapshot taken on next edge
        WAITING  = 2'd2   // Held until downstream acknowledge
    } read_state_t;

endpackage

`default_nettype wire

/* design/pulse_sync.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////
// Channel synchronizer and edge detect
////////////////////

module pulse_sync #(
    parameter int SYNC_STAGES = 2  // Metastability flops in the chain
) (
    input  logic clk_500,
    input  logic rst,
    input  logic pulse_n,  // Active-low pulse, asynchronous
    output logic det       // One-cycle strobe per falling edge
);

    logic [SYNC_STAGES-1:0] sync_q;  // Inverted level, stage 0 first
    logic                   hist_q;  // Previous synchronized level

    // Synchronizer chain on the inverted level
    // Cleared value is "pin high", so nothing fires out of reset
    always_ff @(posedge clk_500) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= ~pulse_n;  // Active-high from here on
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    ////////////////////
    // Edge detect
    ////////////////////

    // Rising edge of the inverted level = falling edge on the pin
    always_ff @(posedge clk_500) begin
        if (rst) begin
            hist_q <= 1'b0;
            det    <= 1'b0;
        end else begin
            hist_q <= sync_q[SYNC_STAGES-1];
            det    <= sync_q[SYNC_STAGES-1] & ~hist_q;  // Registered strobe
        end
    end

    // A held low level must not retrigger
    a_det_single : assert property (
        @(posedge clk_500) disable iff (rst)
        det |=> !det
    ) else $error("pulse_sync: det high for two consecutive cycles");

    // Strobe only after the pin was seen low through the whole chain
    a_det_cause : assert property (
        @(posedge clk_500) disable iff (rst)
        $rose(det) |-> $past(!pulse_n, SYNC_STAGES + 1)
    ) else $error("pulse_sync: det without a preceding low level");

endmodule

`default_nettype wire

/* design/window_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////
// Per-channel pulse history
////////////////////

module window_shifter (
    input  logic                  clk_500,
    input  logic                  rst,
    input  sampler_pkg::ch_bits_t det,     // Strobes from the synchronizers
    output sampler_pkg::frame_t   window   // Current history of all channels
);

    import sampler_pkg::*;

    frame_t window_next;  // Shifted copy, one entry per channel

    // Deserializer per channel
    // Newest strobe enters at the top, everything moves toward bit 0
    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            window_next[c] = {det[c], window[c][WINDOW-1:1]};  // Oldest bit drops out
        end
    end

    // One shift per edge, no enable
    // Keeps running through captures and acknowledge waits
    always_ff @(posedge clk_500) begin
        if (rst) begin
            window <= '0;  // Empty history
        end else begin
            window <= window_next;
        end
    end

endmodule

`default_nettype wire

/* design/event_capture.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////
// Trigger capture FSM
////////////////////

// Stand by, take one snapshot, then hold until the event is acknowledged.
// Triggers outside STAND_BY are dropped on purpose so a frame is never
// overwritten before downstream has saved it.

module event_capture (
    input  logic                  clk_500,
    input  logic                  rst,
    input  sampler_pkg::frame_t   window,       // Live history from the shifter
    input  logic                  trig,         // Capture request, level
    input  logic                  event_saved,  // Downstream acknowledge, level
    output sampler_pkg::capture_t evt           // Registered event output
);

    import sampler_pkg::*;

    read_state_t read_state;       // Current state
    read_state_t read_state_next;
    capture_t    evt_next;         // Zero unless this is the capture cycle

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        read_state_next = read_state;  // Hold by default
        evt_next        = '0;          // Frame reads zero outside capture

        case (read_state)
            STAND_BY: begin
                if (trig) begin
                    read_state_next = READING;  // Snapshot on next edge
                end
            end

            READING: begin
                // Window as it stands between the two edges
                evt_next.ready  = 1'b1;
                evt_next.frame  = window;
                read_state_next = WAITING;
            end

            WAITING: begin
                if (event_saved) begin
                    read_state_next = STAND_BY;  // Acknowledged, rearm
                end
            end

            default: begin
                read_state_next = STAND_BY;  // Unused encoding
            end
        endcase
    end

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk_500) begin
        if (rst) begin
            read_state <= STAND_BY;
            evt        <= '0;  // Ready low, frame empty
        end else begin
            read_state <= read_state_next;
            evt        <= evt_next;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // One-cycle ready pulse per capture
    a_ready_once : assert property (
        @(posedge clk_500) disable iff (rst)
        evt.ready |=> !evt.ready
    ) else $error("event_capture: ready high for more than one cycle");

    // Frame is only valid together with ready
    a_frame_zero : assert property (
        @(posedge clk_500) disable iff (rst)
        !evt.ready |-> (evt.frame == '0)
    ) else $error("event_capture: frame nonzero while ready low");

    // Ready must come out of a READING cycle
    a_ready_src : assert property (
        @(posedge clk_500) disable iff (rst)
        evt.ready |-> ($past(read_state) == READING)
    ) else $error("event_capture: ready without a preceding READING state");

endmodule

`default_nettype wire

/* design/sampler_top.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////
// Pulse sampler top
////////////////////

// Pin to window latency is SYNC_STAGES+1 edges,
// trigger to event is 2 edges.

module sampler_top #(
    parameter int SYNC_STAGES = sampler_pkg::SYNC_STAGES_DEF  // Per-channel sync depth
) (
    input  logic                  clk_500,
    input  logic                  rst,
    input  sampler_pkg::ch_bits_t ch_n,         // Buffered pins, active-low pulses
    input  logic                  trig,         // Capture request level
    input  logic                  event_saved,  // Downstream acknowledge level
    output sampler_pkg::capture_t evt           // Event strobe and frame
);

    import sampler_pkg::*;

    ch_bits_t det;     // One-cycle strobes, one per channel
    frame_t   window;  // Live pulse history

    ////////////////////
    // Input synchronizers
    ////////////////////

    for (genvar c = 0; c < N_CH; c++) begin : g_sync
        pulse_sync #(
            .SYNC_STAGES (SYNC_STAGES)
        ) i_pulse_sync (
            .clk_500 (clk_500),
            .rst     (rst),
            .pulse_n (ch_n[c]),
            .det     (det[c])
        );
    end

    ////////////////////
    // History and capture
    ////////////////////

    window_shifter i_window_shifter (
        .clk_500 (clk_500),
        .rst     (rst),
        .det     (det),
        .window  (window)
    );

    event_capture i_event_capture (
        .clk_500     (clk_500),
        .rst         (rst),
        .window      (window),
        .trig        (trig),
        .event_saved (event_saved),
        .evt         (evt)
    );

endmodule

`default_nettype wire

/* verification/sampler_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sampler_tb;

    import sampler_pkg::*;

    localparam int CLK_PERIOD  = 20;               // ns
    localparam int SYNC_STAGES = SYNC_STAGES_DEF;
    localparam int PULSE_LAT   = SYNC_STAGES + 1;  // Pin sampled low to top of window

    // Test lengths in cycles, upper bounds
    localparam int RST_CYCLES     = 4;
    localparam int IDLE_CYCLES    = 12;
    localparam int READY_WAIT     = 8;               // Max wait for evt.ready
    localparam int CAPTURE_CYCLES = READY_WAIT + 4;  // Trigger, wait, acknowledge
    localparam int SINGLE_CYCLES  = 12 + CAPTURE_CYCLES;
    localparam int RAND_WARMUP    = 70;              // Fill the windows first
    localparam int RAND_CAPTURES  = 8;
    localparam int RAND_GAP_MAX   = 80;
    localparam int RAND_CYCLES    = RAND_WARMUP + RAND_CAPTURES * (RAND_GAP_MAX + CAPTURE_CYCLES);
    localparam int BP_CYCLES      = 90;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + IDLE_CYCLES + SINGLE_CYCLES + RAND_CYCLES
                                   + BP_CYCLES + 200;

    logic     clk_500;
    logic     rst;
    ch_bits_t ch_n;
    ch_bits_t man_n;          // Directed pulses
    ch_bits_t rand_n = '1;    // Random pulses, idle high
    logic     trig;
    logic     event_saved;
    capture_t evt;
    logic     rand_en;

    string    test_name;
    int       cyc = 0;        // Edge index, read at the edge itself
    int       hold_cnt [N_CH];

    // Reference model state
    ch_bits_t    prev_n;
    read_state_t m_state;
    int          trig_edge;
    logic        exp_ready;
    frame_t      exp_frame;
    int          fall_q [N_CH][$];  // Edges that first sampled each channel low
    int          exp_captures  = 0;
    int          seen_captures = 0;

    int err_ready   = 0;
    int err_frame   = 0;
    int err_zero    = 0;
    int err_repeat  = 0;
    int err_missing = 0;

    assign ch_n = man_n & rand_n;  // Either source pulls a pin low

    sampler_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_sampler_top (
        .clk_500     (clk_500),
        .rst         (rst),
        .ch_n        (ch_n),
        .trig        (trig),
        .event_saved (event_saved),
        .evt         (evt)
    );

    initial begin
        clk_500 = 1'b0;
        forever #(CLK_PERIOD / 2) clk_500 = ~clk_500;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Frame for a trigger sampled at edge t
    function automatic frame_t predict_frame(input int t);
        frame_t f;
        int     pos;
        f = '0;
        for (int c = 0; c < N_CH; c++) begin
            for (int i = 0; i < fall_q[c].size(); i++) begin
                pos = WINDOW - 1 - (t - fall_q[c][i] - PULSE_LAT);  // Newest at the top
                if (pos >= 0 && pos < WINDOW) begin
                    f[c][pos] = 1'b1;
                end
            end
        end
        return f;
    endfunction

    always @(posedge clk_500) begin
        cyc <= cyc + 1;
        if (rst) begin
            prev_n    <= '1;  // Synchronizers read as pin high
            m_state   <= STAND_BY;
            exp_ready <= 1'b0;
            exp_frame <= '0;
            for (int c = 0; c < N_CH; c++) begin
                fall_q[c].delete();
            end
        end else begin
            for (int c = 0; c < N_CH; c++) begin
                if (prev_n[c] && !ch_n[c]) begin
                    fall_q[c].push_back(cyc);  // High then low
                end
                // Long gone from any window
                while (fall_q[c].size() > 0 && cyc - fall_q[c][0] > WINDOW + 8) begin
                    void'(fall_q[c].pop_front());
                end
            end
            prev_n    <= ch_n;
            exp_ready <= 1'b0;
            exp_frame <= '0;
            case (m_state)
                STAND_BY: begin
                    if (trig) begin
                        m_state   <= READING;
                        trig_edge <= cyc;
                    end
                end
                READING: begin
                    exp_ready <= 1'b1;  // Capture edge t+1
                    exp_frame <= predict_frame(trig_edge);
                    m_state   <= WAITING;
                    exp_captures++;
                end
                WAITING: begin
                    if (event_saved) begin
                        m_state <= STAND_BY;
                    end
                end
                default: m_state <= STAND_BY;
            endcase
        end
    end

    always @(posedge clk_500) begin
        if (cyc >= 1 && evt.ready) begin
            seen_captures++;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_ready_match : assert property (
        @(posedge clk_500) (cyc >= 1) |-> (evt.ready == exp_ready)
    ) else begin
        err_ready++;
        $display("FAILED %s: evt.ready expected %0b actual %0b",
                 test_name, $sampled(exp_ready), $sampled(evt.ready));
    end

    a_frame_match : assert property (
        @(posedge clk_500) (cyc >= 1) |-> (evt.frame == exp_frame)
    ) else begin
        err_frame++;
        $display("FAILED %s: evt.frame expected %h actual %h",
                 test_name, $sampled(exp_frame), $sampled(evt.frame));
    end

    // Frame empty outside the capture cycle
    a_frame_zero : assert property (
        @(posedge clk_500) (cyc >= 1 && !evt.ready) |-> (evt.frame == '0)
    ) else begin
        err_zero++;
        $display("FAILED %s: idle evt.frame expected %h actual %h",
                 test_name, frame_t'('0), $sampled(evt.frame));
    end

    a_ready_single : assert property (
        @(posedge clk_500) evt.ready |=> !evt.ready
    ) else begin
        err_repeat++;
        $display("Test %s: evt.ready stayed high for two consecutive cycles", test_name);
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Random pin driver, one hold counter per channel
    always @(posedge clk_500) begin
        if (!rand_en) begin
            rand_n <= '1;
            for (int c = 0; c < N_CH; c++) begin
                hold_cnt[c] <= 0;
            end
        end else begin
            for (int c = 0; c < N_CH; c++) begin
                if (hold_cnt[c] == 0) begin
                    rand_n[c] <= ~rand_n[c];
                    if (rand_n[c] && ($urandom % 8) == 0) begin
                        hold_cnt[c] <= 40 + int'($urandom % 60);  // Long low level
                    end else if (rand_n[c]) begin
                        hold_cnt[c] <= int'($urandom % 8);        // Short pulse
                    end else begin
                        hold_cnt[c] <= int'($urandom % 24);       // Gap
                    end
                end else begin
                    hold_cnt[c] <= hold_cnt[c] - 1;
                end
            end
        end
    end

    // Trigger and wait for the event strobe
    task automatic capture_event();
        bit got;
        int waited;
        got    = 1'b0;
        waited = 0;
        @(posedge clk_500);
        trig <= 1'b1;
        @(posedge clk_500);
        trig <= 1'b0;
        while (!got && waited < READY_WAIT) begin
            @(posedge clk_500);
            got = evt.ready;
            waited++;
        end
        if (!got) begin
            err_missing++;
            $display("Test %s: no evt.ready within %0d cycles of the trigger (model in %s)",
                     test_name, READY_WAIT, m_state.name());
        end
    endtask

    // Trigger that the FSM must drop while it waits
    task automatic fire_ignored_trigger();
        @(posedge clk_500);
        trig <= 1'b1;
        @(posedge clk_500);
        trig <= 1'b0;
        repeat (READY_WAIT) @(posedge clk_500);
    endtask

    task automatic acknowledge();
        @(posedge clk_500);
        event_saved <= 1'b1;
        @(posedge clk_500);
        event_saved <= 1'b0;
    endtask

    initial begin
        int gap;
        int total;

        void'($urandom(39));
        rst         = 1'b1;
        man_n       = '1;
        trig        = 1'b0;
        event_saved = 1'b0;
        rand_en     = 1'b0;
        test_name   = "reset_idle";

        repeat (RST_CYCLES) @(posedge clk_500);
        rst <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk_500);  // No trigger, evt stays empty

        // One falling edge on channel 5
        test_name = "single_pulse";
        @(posedge clk_500);
        man_n[5] <= 1'b0;
        repeat (3) @(posedge clk_500);
        man_n[5] <= 1'b1;
        repeat (6) @(posedge clk_500);
        capture_event();
        acknowledge();

        test_name = "random_pulses";
        @(posedge clk_500);
        rand_en <= 1'b1;
        repeat (RAND_WARMUP) @(posedge clk_500);
        for (int n = 0; n < RAND_CAPTURES; n++) begin
            gap = 1 + int'($urandom % RAND_GAP_MAX);
            repeat (gap) @(posedge clk_500);
            capture_event();
            acknowledge();
        end

        // Hold off the acknowledge, pins keep toggling
        test_name = "back_pressure";
        capture_event();
        for (int n = 0; n < 3; n++) begin
            fire_ignored_trigger();
        end
        acknowledge();
        @(posedge clk_500);
        rand_en <= 1'b0;
        repeat (2) @(posedge clk_500);  // Pins back high
        man_n[11] <= 1'b0;
        repeat (2) @(posedge clk_500);
        man_n[11] <= 1'b1;
        repeat (8) @(posedge clk_500);
        capture_event();
        acknowledge();

        repeat (4) @(posedge clk_500);
        if (seen_captures != exp_captures) begin
            err_missing++;
            $display("FAILED %s: event count expected %0d actual %0d",
                     test_name, exp_captures, seen_captures);
        end

        total = err_ready + err_frame + err_zero + err_repeat + err_missing;
        $display("Error counts: ready %0d, frame %0d, idle frame %0d, repeat %0d, missing %0d",
                 err_ready, err_frame, err_zero, err_repeat, err_missing);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/sampler_pkg.sv
design/pulse_sync.sv
design/window_shifter.sv
design/event_capture.sv
design/sampler_top.sv
verification/sampler_tb.sv

/* Makefile */
# Verilator build and run for the pulse sampler

VERILATOR ?= verilator
TOP       ?= sampler_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuild only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
